// ==== tb.f ====
pet_bus_pkg.sv
pet_timing_pkg.sv
bus_timing.sv
addr_decode.sv
reset_ctrl.sv
pet_main.sv
pet_top.sv
tb_pet_top.sv

// ==== Makefile ====
TOOL  := verilator
FLAGS := --binary --timing -j 0
TOP   := tb_pet_top
FLIST := tb.f
OBJ   := obj_dir
LOG   := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	@grep -Fqx '** PASS **' $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)

// ==== tb_pet_top.sv ====
// Testbench for the PET glue logic top level
// Directed tests for reset release, CPU clock, RAM and ROM strobes,
// I/O chip selects, video RAM mirroring and external reset on RES

`timescale 1ns/1ps

module tb_pet_top
    import pet_bus_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;   // Tests need well under this

    logic          clk16_i;
    logic          rst_n_i;
    logic [15:0]   bus_addr_15_0_i;
    logic [15:0]   bus_addr_15_0_o;
    logic [15:0]   bus_addr_15_0_oe;
    logic          bus_addr_16_o;
    logic [7:0]    bus_data_7_0_i;
    logic [7:0]    bus_data_7_0_o;
    logic [7:0]    bus_data_7_0_oe;
    logic          bus_rw_ni;
    logic          bus_rw_no;
    logic          bus_rw_noe;
    logic          cpu_clk_o;
    logic          cpu_res_ni;
    logic          cpu_res_no;
    logic          cpu_res_noe;
    logic          cpu_irq_ni;
    logic          cpu_irq_no;
    logic          cpu_irq_noe;
    logic          cpu_nmi_ni;
    logic          cpu_nmi_no;
    logic          cpu_nmi_noe;
    logic          cpu_ready_o;
    logic          cpu_be_o;
    logic          ram_ce_no;
    logic          ram_oe_no;
    logic          ram_we_no;
    logic [11:10]  ram_addr_o;
    logic          pia1_cs2_no;
    logic          pia2_cs2_no;
    logic          via_cs2_no;
    logic          io_oe_no;

    logic          ext_pull;                // Testbench pulls RES low
    int            cycles = 0;              // clk16_i cycles since start
    int            rel_count = 0;           // Cycle count at tick 0 after reset
    int            tests = 0;
    int            checks = 0;
    int            errors = 0;

    // Wired-or RES line, low if the FPGA or the testbench pulls it
    assign cpu_res_ni = !(ext_pull || (cpu_res_noe && !cpu_res_no));

    pet_top UUT (.*);

    initial begin
        clk16_i = 1'b0;
        forever #50 clk16_i = ~clk16_i;    // 100 ns period
    end

    always @(posedge clk16_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("error %s: got %0h, expected %0h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0) begin
            $display("test %-14s ok", name);
        end else begin
            $display("test %-14s %0d errors", name, errors - err0);
        end
    endtask

    // Position within the CPU cycle, counted from the tick 0 after reset
    function automatic logic [3:0] tick_now();
        return 4'((cycles - rel_count) % 16);
    endfunction

    // Select pins read back as active-high
    function automatic bus_sel_t pins_active();
        bus_sel_t s;
        s.ram_oe  = !ram_oe_no;
        s.ram_we  = !ram_we_no;
        s.pia1_cs = !pia1_cs2_no;
        s.pia2_cs = !pia2_cs2_no;
        s.via_cs  = !via_cs2_no;
        s.io_oe   = !io_oe_no;
        return s;
    endfunction

    // PET memory map applied to one tick of a cycle
    function automatic bus_sel_t expected_sel(input logic [15:0] addr, input logic rw_n,
                                              input logic [3:0] t);
        bus_sel_t e;
        logic     io_page;
        logic     writable;
        logic     phi2_hi;
        logic     strobe;
        io_page  = (addr >= 16'hE800) && (addr <= 16'hE8FF);
        writable = (addr <= 16'h8FFF);          // Main RAM and screen RAM
        phi2_hi  = (t >= 4'd8);
        strobe   = (t >= 4'd10);
        e = '0;
        e.io_oe   = phi2_hi && io_page;
        e.pia1_cs = e.io_oe && (addr[7:4] == 4'h1);
        e.pia2_cs = e.io_oe && (addr[7:4] == 4'h2);
        e.via_cs  = e.io_oe && (addr[7:4] == 4'h4);
        e.ram_oe  = strobe && rw_n && !io_page;
        e.ram_we  = strobe && (t <= 4'd14) && !rw_n && writable;
        return e;
    endfunction

    task automatic wait_tick(input logic [3:0] t);
        @(negedge clk16_i);
        while (tick_now() != t) @(negedge clk16_i);
    endtask

    // One CPU cycle, address set up at tick 2 and checked tick by tick
    task automatic bus_cycle(input logic [15:0] addr, input logic rw_n);
        logic [3:0] t;
        logic [1:0] exp_ra;
        bus_sel_t   exp_sel;
        exp_ra = (addr[15:12] == 4'h8) ? 2'b00 : addr[11:10];
        wait_tick(4'd1);
        @(posedge clk16_i);
        bus_addr_15_0_i <= addr;
        bus_rw_ni       <= rw_n;
        repeat (16) begin
            @(negedge clk16_i);
            t = tick_now();
            exp_sel = expected_sel(addr, rw_n, t);
            check($sformatf("selects @tick %0d", t), 32'(pins_active()), 32'(exp_sel));
            check("cpu_clk_o", 32'(cpu_clk_o), 32'(t >= 4'd8));
            if (t >= 4'd7 || t < 4'd2) begin
                check("ram_addr_o", 32'(ram_addr_o), 32'(exp_ra));
            end
        end
    endtask

    // Follow RES while it is held, counting clocks and phi2 falls
    task automatic watch_reset_hold(output int clocks, output int falls);
        logic prev_clk;
        clocks   = 0;
        falls    = 0;
        prev_clk = cpu_clk_o;
        while (cpu_res_no === 1'b0) begin
            check("cpu_res_noe", 32'(cpu_res_noe), 32'd1);
            check("cpu_ready_o", 32'(cpu_ready_o), 32'd0);
            check("cpu_be_o", 32'(cpu_be_o), 32'd0);
            check("select pins", 32'(pins_active()), 32'd0);
            clocks++;
            @(negedge clk16_i);
            if (prev_clk && !cpu_clk_o) falls++;
            prev_clk = cpu_clk_o;
        end
        // Ready and bus enable switch with the RES release
        check("cpu_ready_o", 32'(cpu_ready_o), 32'd1);
        check("cpu_be_o", 32'(cpu_be_o), 32'd1);
        check("cpu_res_noe", 32'(cpu_res_noe), 32'd0);
    endtask

    task automatic test_reset_release();
        int err0;
        int clocks;
        int falls;
        err0 = errors;
        repeat (9) @(posedge clk16_i);
        @(negedge clk16_i);
        check("cpu_res_no", 32'(cpu_res_no), 32'd0);
        check("cpu_res_noe", 32'(cpu_res_noe), 32'd1);
        check("ram_ce_no", 32'(ram_ce_no), 32'd0);
        check("bus_addr_15_0_oe", 32'(bus_addr_15_0_oe), 32'd0);
        check("bus_addr_15_0_o", 32'(bus_addr_15_0_o), 32'd0);
        check("bus_addr_16_o", 32'(bus_addr_16_o), 32'd0);
        check("bus_data_7_0_oe", 32'(bus_data_7_0_oe), 32'd0);
        check("bus_data_7_0_o", 32'(bus_data_7_0_o), 32'd0);
        check("bus_rw_noe", 32'(bus_rw_noe), 32'd0);
        check("bus_rw_no", 32'(bus_rw_no), 32'd1);
        check("cpu_irq_noe", 32'(cpu_irq_noe), 32'd0);
        check("cpu_irq_no", 32'(cpu_irq_no), 32'd1);
        check("cpu_nmi_noe", 32'(cpu_nmi_noe), 32'd0);
        check("cpu_nmi_no", 32'(cpu_nmi_no), 32'd1);
        @(posedge clk16_i);
        rst_n_i <= 1'b1;
        @(negedge clk16_i);
        rel_count = cycles;                     // First tick 0
        watch_reset_hold(clocks, falls);
        check("reset hold clocks", 32'(clocks), 32'd128);
        check("reset hold cycles", 32'(falls), 32'd8);
        check("release tick", 32'(tick_now()), 32'd0);
        end_test("reset release", err0);
    endtask

    task automatic test_cpu_clock();
        int err0;
        int high_cnt;
        int period;
        err0 = errors;
        repeat (3) begin
            while (cpu_clk_o !== 1'b0) @(negedge clk16_i);
            while (cpu_clk_o !== 1'b1) @(negedge clk16_i);
            check("phi2 rise tick", 32'(tick_now()), 32'd8);
            high_cnt = 0;
            while (cpu_clk_o === 1'b1) begin
                high_cnt++;
                @(negedge clk16_i);
            end
            period = high_cnt;
            while (cpu_clk_o === 1'b0) begin
                period++;
                @(negedge clk16_i);
            end
            check("cpu_clk_o high", 32'(high_cnt), 32'd8);
            check("cpu_clk_o period", 32'(period), 32'd16);
        end
        end_test("cpu clock", err0);
    endtask

    task automatic test_ram_rom();
        int          err0;
        logic [15:0] ram_a;
        logic [15:0] rom_a;
        err0  = errors;
        ram_a = 16'($urandom()) & 16'h7FFF;
        bus_cycle(ram_a, 1'b1);
        ram_a = 16'($urandom()) & 16'h7FFF;
        bus_cycle(ram_a, 1'b0);
        rom_a = 16'h9000 + 16'($urandom() % 32'h7000);
        if (rom_a[15:8] == 8'hE8) rom_a[8] = 1'b1;  // Keep out of the I/O page
        bus_cycle(rom_a, 1'b0);                     // Write protected
        bus_cycle(rom_a, 1'b1);
        end_test("ram and rom", err0);
    endtask

    task automatic test_io_selects();
        int err0;
        err0 = errors;
        bus_cycle(16'hE810, 1'b1);              // PIA1
        bus_cycle(16'hE820, 1'b1);              // PIA2
        bus_cycle(16'hE840, 1'b1);              // VIA
        bus_cycle(16'hE800, 1'b1);              // Buffer only
        bus_cycle(16'hE840, 1'b0);
        end_test("io selects", err0);
    endtask

    task automatic test_vram_mirror();
        int err0;
        err0 = errors;
        bus_cycle(16'h8C55, 1'b1);
        check("ram_addr_o", 32'(ram_addr_o), 32'h0);
        bus_cycle(16'h0C55, 1'b1);
        check("ram_addr_o", 32'(ram_addr_o), 32'h3);
        bus_cycle(16'h8455, 1'b0);              // Screen write
        check("ram_addr_o", 32'(ram_addr_o), 32'h0);
        end_test("vram mirror", err0);
    endtask

    task automatic test_ext_reset();
        int err0;
        int clocks;
        int falls;
        err0 = errors;
        wait_tick(4'd2);
        @(posedge clk16_i);
        ext_pull <= 1'b1;                       // Reset button pressed
        repeat (4) @(posedge clk16_i);
        ext_pull <= 1'b0;
        @(negedge clk16_i);
        check("cpu_res_no", 32'(cpu_res_no), 32'd0);
        watch_reset_hold(clocks, falls);
        check("ext reset cycles", 32'(falls), 32'd8);
        bus_cycle(16'h1234, 1'b1);              // Bus live again
        end_test("ext reset", err0);
    endtask

    initial begin
        rst_n_i         = 1'b0;
        bus_addr_15_0_i = '0;
        bus_data_7_0_i  = '0;
        bus_rw_ni       = 1'b1;
        cpu_irq_ni      = 1'b1;
        cpu_nmi_ni      = 1'b1;
        ext_pull        = 1'b0;
        void'($urandom(32'h8c95));

        test_reset_release();
        test_cpu_clock();
        test_ram_rom();
        test_io_selects();
        test_vram_mirror();
        test_ext_reset();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== pet_top.sv ====
// PET glue logic pin adapter
// Turns active-low and open-drain pins into active-high signals for the
// core, drives RES as a wired-or output and parks the bus drivers,
// since the FPGA never masters the address or data bus

`timescale 1ns/1ps

module pet_top
    import pet_bus_pkg::*;
(
    input  logic              clk16_i,              // 16 MHz system clock
    input  logic              rst_n_i,

    // System bus
    input  logic [ADDR_W-1:0] bus_addr_15_0_i,      // CPU address
    output logic [ADDR_W-1:0] bus_addr_15_0_o,
    output logic [ADDR_W-1:0] bus_addr_15_0_oe,
    output logic              bus_addr_16_o,        // Output only, CPU has 16 bits
    input  logic [DATA_W-1:0] bus_data_7_0_i,
    output logic [DATA_W-1:0] bus_data_7_0_o,
    output logic [DATA_W-1:0] bus_data_7_0_oe,
    input  logic              bus_rw_ni,            // 0 = write, 1 = read
    output logic              bus_rw_no,
    output logic              bus_rw_noe,

    // CPU
    output logic              cpu_clk_o,            // 1 MHz phi2
    input  logic              cpu_res_ni,           // Open drain, wired-or
    output logic              cpu_res_no,
    output logic              cpu_res_noe,
    input  logic              cpu_irq_ni,           // Open drain
    output logic              cpu_irq_no,
    output logic              cpu_irq_noe,
    input  logic              cpu_nmi_ni,           // Open drain
    output logic              cpu_nmi_no,
    output logic              cpu_nmi_noe,
    output logic              cpu_ready_o,          // 0 = halt
    output logic              cpu_be_o,             // 0 = CPU bus high impedance

    // RAM
    output logic              ram_ce_no,
    output logic              ram_oe_no,
    output logic              ram_we_no,
    output logic [11:10]      ram_addr_o,           // Mirrors video RAM

    // I/O
    output logic              pia1_cs2_no,
    output logic              pia2_cs2_no,
    output logic              via_cs2_no,
    output logic              io_oe_no
);

    bus_sel_t sel;                                  // Active-high selects from core
    logic     cpu_res_i;
    logic     cpu_res_o;

    // No bus mastering, so address, data and rw stay released
    assign bus_addr_15_0_oe = '0;
    assign bus_addr_15_0_o  = '0;
    assign bus_addr_16_o    = 1'b0;
    assign bus_data_7_0_oe  = '0;
    assign bus_data_7_0_o   = '0;
    assign bus_rw_no        = 1'b1;                 // Would read as read if enabled
    assign bus_rw_noe       = 1'b0;

    // Open drain RES, pulled low only while asserted
    assign cpu_res_i   = !cpu_res_ni;
    assign cpu_res_no  = !cpu_res_o;
    assign cpu_res_noe = cpu_res_o;

    // No interrupt sources here, leave IRQ and NMI floating high
    assign cpu_irq_no  = 1'b1;
    assign cpu_irq_noe = 1'b0;
    assign cpu_nmi_no  = 1'b1;
    assign cpu_nmi_noe = 1'b0;

    // RAM always chip-enabled, accesses are strobed by OE and WE
    assign ram_ce_no   = 1'b0;
    assign ram_oe_no   = !sel.ram_oe;
    assign ram_we_no   = !sel.ram_we;
    assign pia1_cs2_no = !sel.pia1_cs;
    assign pia2_cs2_no = !sel.pia2_cs;
    assign via_cs2_no  = !sel.via_cs;
    assign io_oe_no    = !sel.io_oe;

    pet_main #(
        .RESET_CYCLES (8)
    ) u_pet_main (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .addr_i      (bus_addr_15_0_i),
        .rw_n_i      (bus_rw_ni),
        .ext_res_i   (cpu_res_i),
        .cpu_clk_o   (cpu_clk_o),
        .sel_o       (sel),
        .ram_addr_o  (ram_addr_o),
        .cpu_res_o   (cpu_res_o),
        .cpu_ready_o (cpu_ready_o),
        .cpu_be_o    (cpu_be_o)
    );

endmodule

// ==== pet_main.sv ====
// PET glue logic core
// Cycle timing, address decode and CPU reset control, all in
// active-high form, with the pin polarity handled one level up

`timescale 1ns/1ps

module pet_main
    import pet_bus_pkg::*;
    import pet_timing_pkg::*;
#(
    parameter int RESET_CYCLES = 8
) (
    input  logic              clk16_i,
    input  logic              rst_n_i,
    input  logic [ADDR_W-1:0] addr_i,
    input  logic              rw_n_i,
    input  logic              ext_res_i,    // RES as seen on the pin
    output logic              cpu_clk_o,
    output bus_sel_t          sel_o,
    output logic [11:10]      ram_addr_o,
    output logic              cpu_res_o,
    output logic              cpu_ready_o,
    output logic              cpu_be_o
);

    phase_t phase;                          // Tick and strobes of current cycle
    logic   run;                            // CPU out of reset

    bus_timing u_bus_timing (
        .clk16_i   (clk16_i),
        .rst_n_i   (rst_n_i),
        .phase_o   (phase),
        .cpu_clk_o (cpu_clk_o)
    );

    addr_decode u_addr_decode (
        .clk16_i    (clk16_i),
        .rst_n_i    (rst_n_i),
        .phase_i    (phase),
        .run_i      (run),
        .addr_i     (addr_i),
        .rw_n_i     (rw_n_i),
        .sel_o      (sel_o),
        .ram_addr_o (ram_addr_o)
    );

    reset_ctrl #(
        .RESET_CYCLES (RESET_CYCLES)
    ) u_reset_ctrl (
        .clk16_i     (clk16_i),
        .rst_n_i     (rst_n_i),
        .phase_i     (phase),
        .ext_res_i   (ext_res_i),
        .cpu_res_o   (cpu_res_o),
        .cpu_ready_o (cpu_ready_o),
        .cpu_be_o    (cpu_be_o),
        .run_o       (run)
    );

endmodule

// ==== reset_ctrl.sv ====
// CPU reset control
// Holds the 6502 in reset for RESET_CYCLES CPU cycles after FPGA reset
// or after an external reset on the wired-or RES line, then lets it run

`timescale 1ns/1ps

module reset_ctrl
    import pet_timing_pkg::*;
#(
    parameter int RESET_CYCLES = 8      // CPU cycles of RES assertion
) (
    input  logic   clk16_i,
    input  logic   rst_n_i,
    input  phase_t phase_i,
    input  logic   ext_res_i,           // RES pin level, active high
    output logic   cpu_res_o,           // Drive RES low
    output logic   cpu_ready_o,
    output logic   cpu_be_o,
    output logic   run_o                // Enables the bus selects
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] cnt_q;            // Completed cycles in reset
    logic             res_q;
    logic [1:0]       ext_sync_q;       // RES pin synchronizer
    logic [1:0]       drive_hist_q;     // Own drive, delayed to match sync
    logic             ext_seen;

    // Someone else pulled RES while we were not driving it
    assign ext_seen = ext_sync_q[1] && !drive_hist_q[1] && !res_q;

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            ext_sync_q   <= '0;
            drive_hist_q <= '1;         // Driving from reset
        end else begin
            ext_sync_q   <= {ext_sync_q[0], ext_res_i};
            drive_hist_q <= {drive_hist_q[0], res_q};
        end
    end

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            res_q <= 1'b1;
            cnt_q <= '0;
        end else if (ext_seen) begin
            res_q <= 1'b1;              // Restart the full reset period
            cnt_q <= '0;
        end else if (res_q && phase_i.cycle_end) begin
            if (cnt_q == CNT_W'(RESET_CYCLES - 1)) begin
                res_q <= 1'b0;          // Release at a cycle boundary
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + CNT_W'(1);
            end
        end
    end

    assign cpu_res_o   = res_q;
    assign cpu_ready_o = !res_q;        // Same edge as RES release
    assign cpu_be_o    = !res_q;
    assign run_o       = !res_q;

endmodule

// ==== addr_decode.sv ====
// PET address decoder
// Captures the CPU address once per cycle, sorts it into RAM, video RAM,
// I/O or ROM and times the RAM strobes and chip selects to the cycle
// Video RAM is 1 KB, mirrored by forcing RAM A[11:10] low

`timescale 1ns/1ps

module addr_decode
    import pet_bus_pkg::*;
    import pet_timing_pkg::*;
(
    input  logic              clk16_i,
    input  logic              rst_n_i,
    input  phase_t            phase_i,
    input  logic              run_i,        // Low while CPU held in reset
    input  logic [ADDR_W-1:0] addr_i,       // CPU address pins
    input  logic              rw_n_i,       // 1 = read, 0 = write
    output bus_sel_t          sel_o,
    output logic [11:10]      ram_addr_o    // Replaces A[11:10] at the RAM
);

    region_e           region_d;
    region_e           region_q;            // Region of current cycle
    logic              rw_n_q;
    logic [3:0]        io_ofs_q;            // A[7:4], picks the I/O chip
    logic [TICK_W-1:0] tick_nxt;
    logic              win_phi2;            // Next tick in 8-15
    logic              win_acc;             // Next tick in 10-15
    logic              win_we;              // Next tick in 10-14
    logic              is_io;
    logic              is_ram;              // RAM or video RAM, both writable
    bus_sel_t          sel_d;

    // Classify the live address pins
    always_comb begin
        if (!addr_i[ADDR_W-1]) begin
            region_d = REGION_RAM;
        end else if (addr_i[ADDR_W-1 -: 4] == VRAM_HI) begin
            region_d = REGION_VRAM;
        end else if (addr_i[ADDR_W-1 -: 8] == IO_PAGE) begin
            region_d = REGION_IO;
        end else begin
            region_d = REGION_ROM;          // Everything else from 9000 up
        end
    end

    // Address phase capture at tick 6, held until the next tick 6
    always_ff @(posedge clk16_i) begin
        if (phase_i.addr_stb) begin
            region_q   <= region_d;
            rw_n_q     <= rw_n_i;
            io_ofs_q   <= addr_i[7:4];
            ram_addr_o <= (region_d == REGION_VRAM) ? 2'b00 : addr_i[11:10];
        end
    end

    // Selects are registered, so the windows test the coming tick
    // 16 ticks fill the counter, so the add wraps from 15 to 0
    assign tick_nxt = phase_i.tick + TICK_W'(1);
    assign win_phi2 = (tick_nxt >= TICK_PHI2);
    assign win_acc  = (tick_nxt >= TICK_ACC);
    assign win_we   = win_acc && (tick_nxt <= TICK_WE_END);

    assign is_io  = (region_q == REGION_IO);
    assign is_ram = (region_q == REGION_RAM) || (region_q == REGION_VRAM);

    always_comb begin
        sel_d = '0;
        if (run_i) begin
            sel_d.io_oe   = win_phi2 && is_io;  // Any E8xx access
            sel_d.pia1_cs = win_phi2 && is_io && (io_ofs_q == PIA1_OFS);
            sel_d.pia2_cs = win_phi2 && is_io && (io_ofs_q == PIA2_OFS);
            sel_d.via_cs  = win_phi2 && is_io && (io_ofs_q == VIA_OFS);
            sel_d.ram_oe  = win_acc && rw_n_q && !is_io;    // RAM, VRAM and ROM reads
            sel_d.ram_we  = win_we && !rw_n_q && is_ram;    // ROM stays write protected
        end
    end

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            sel_o <= '0;
        end else begin
            sel_o <= sel_d;
        end
    end

endmodule

// ==== bus_timing.sv ====
// CPU cycle timing
// Divides the 16 MHz clock into 16-tick CPU cycles, drives the
// 1 MHz CPU clock and decodes the tick into phase and strobes

`timescale 1ns/1ps

module bus_timing
    import pet_timing_pkg::*;
(
    input  logic   clk16_i,             // 16 MHz system clock
    input  logic   rst_n_i,
    output phase_t phase_o,             // Tick, phase and strobes
    output logic   cpu_clk_o            // 1 MHz phi2 to the 6502
);

    logic [TICK_W-1:0] tick_q;          // Position within the CPU cycle
    logic [TICK_W-1:0] tick_nxt;
    bus_phase_e        phase;

    // Wrap after the last tick of the cycle
    assign tick_nxt = (tick_q == TICK_LAST) ? '0 : tick_q + TICK_W'(1);

    always_ff @(posedge clk16_i) begin
        if (!rst_n_i) begin
            tick_q    <= '0;            // Tick 0 on first cycle out of reset
            cpu_clk_o <= 1'b0;
        end else begin
            tick_q    <= tick_nxt;
            // Look ahead one tick so the pin is high exactly on ticks 8-15
            cpu_clk_o <= (tick_nxt >= TICK_PHI2);
        end
    end

    // Coarse phase of the cycle
    always_comb begin
        if (tick_q < TICK_PHI2) begin
            phase = PHASE_SETUP;        // Address settling, phi2 low
        end else if (tick_q < TICK_ACC) begin
            phase = PHASE_DECODE;       // Selects up, RAM not yet strobed
        end else begin
            phase = PHASE_ACCESS;
        end
    end

    always_comb begin
        phase_o.tick      = tick_q;
        phase_o.phase     = phase;
        phase_o.phi2      = (tick_q >= TICK_PHI2);  // Matches cpu_clk_o
        phase_o.addr_stb  = (tick_q == TICK_ADDR);
        phase_o.cycle_end = (tick_q == TICK_LAST);
    end

endmodule

// ==== pet_timing_pkg.sv ====
// PET cycle timing definitions
// Tick positions within one 1 MHz CPU cycle of 16 clk16_i periods
// and the phase bundle sent from the timing block to its users

package pet_timing_pkg;

    localparam int TICKS_PER_CYCLE = 16;                // clk16_i periods per CPU cycle
    localparam int TICK_W          = $clog2(TICKS_PER_CYCLE);

    localparam logic [TICK_W-1:0] TICK_ADDR   = TICK_W'(6);     // Sample address and rw
    localparam logic [TICK_W-1:0] TICK_PHI2   = TICK_W'(8);     // phi2 rises
    localparam logic [TICK_W-1:0] TICK_ACC    = TICK_W'(10);    // RAM strobes start
    localparam logic [TICK_W-1:0] TICK_WE_END = TICK_W'(14);    // Last tick of WE
    localparam logic [TICK_W-1:0] TICK_LAST   = TICK_W'(TICKS_PER_CYCLE - 1);

    typedef enum logic [1:0] {
        PHASE_SETUP  = 2'd0,                            // Ticks 0-7, phi2 low
        PHASE_DECODE = 2'd1,                            // Ticks 8-9
        PHASE_ACCESS = 2'd2                             // Ticks 10-15
    } bus_phase_e;

    typedef struct packed {
        logic [TICK_W-1:0] tick;
        bus_phase_e        phase;
        logic              phi2;
        logic              addr_stb;                    // High on TICK_ADDR
        logic              cycle_end;                   // High on last tick
    } phase_t;

endpackage

// ==== pet_bus_pkg.sv ====
// PET bus definitions
// Address and data widths, the PET memory map and the active-high
// select bundle passed from the decoder to the pin adapter

package pet_bus_pkg;

    localparam int ADDR_W = 16;                 // 6502 address bus
    localparam int DATA_W = 8;                  // 6502 data bus

    // Memory map, upper address bits
    localparam logic [3:0] VRAM_HI  = 4'h8;     // 8000-8FFF video RAM
    localparam logic [7:0] IO_PAGE  = 8'hE8;    // E8xx I/O page

    // Chip offsets within the I/O page, matched on A[7:4]
    localparam logic [3:0] PIA1_OFS = 4'h1;     // E810 keyboard PIA
    localparam logic [3:0] PIA2_OFS = 4'h2;     // E820 IEEE-488 PIA
    localparam logic [3:0] VIA_OFS  = 4'h4;     // E840 user port VIA

    // Region of the current CPU access
    typedef enum logic [1:0] {
        REGION_RAM  = 2'd0,                     // 0000-7FFF
        REGION_VRAM = 2'd1,                     // 8000-8FFF, 1 KB seen four times
        REGION_IO   = 2'd2,                     // E8xx
        REGION_ROM  = 2'd3                      // Rest of 9000-FFFF, write protected
    } region_e;

    // Bus strobes and chip selects, all active high
    typedef struct packed {
        logic ram_oe;                           // RAM drives data bus
        logic ram_we;                           // RAM write strobe
        logic pia1_cs;
        logic pia2_cs;
        logic via_cs;
        logic io_oe;                            // I/O data buffer enable
    } bus_sel_t;

endpackage
